//--- rtl/dma_pkg.sv
// --------------------------------------------------------------------------
// shared constants, register map and types of the DMA engine
// every DMA RTL block imports this package
// --------------------------------------------------------------------------
package dma_pkg;

  // data memory window seen by the engine, physical byte addresses
  localparam logic [31:0] ADDR_DATA_BASE = 32'h2000_0000;
  localparam logic [31:0] ADDR_DATA_END  = 32'h2000_0FFF;

  // bus word and FIFO entry widths
  localparam int WORD_W  = 32;
  localparam int ENTRY_W = 2 * WORD_W;

  // register offsets on the bus
  typedef enum logic [7:0] {
    REG_SRC_ADDR  = 8'h00,
    REG_LEN_WORDS = 8'h04,
    REG_DMA_CTRL  = 8'h08
  } dma_reg_e;

  // bit positions in the CTRL register
  localparam int CTRL_START = 0;
  localparam int CTRL_DONE  = 1;
  localparam int CTRL_ERR   = 2;
  localparam int CTRL_BUSY  = 3;

  // transfer sequencer states
  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_SETUP = 3'd1,
    ST_RD0   = 3'd2,
    ST_RD1   = 3'd3,
    ST_PUSH  = 3'd4
  } dma_state_e;

  // bus request, valid is a single-cycle strobe
  typedef struct packed {
    logic              valid;
    logic              write;
    dma_reg_e          offset;
    logic [WORD_W-1:0] wdata;
  } dma_req_t;

  // programmed transfer
  typedef struct packed {
    logic [31:0] src_addr;
    logic [31:0] len_words;
  } dma_cfg_t;

  // one-cycle status events from the sequencer
  typedef struct packed {
    logic launch;
    logic finish;
    logic reject;
    logic zero_len;
  } dma_evt_t;

  // read side control from the sequencer to the packer
  typedef struct packed {
    logic en;
    logic hi;
    logic push;
  } dma_rd_t;

endpackage

//--- rtl/dma_reg_decode.sv
// --------------------------------------------------------------------------
// DMA register file with bus decode, sticky DONE/ERR and readback mux
// feeds the programmed transfer and a start strobe to the sequencer
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module dma_reg_decode
  import dma_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  dma_req_t          req,
  output logic [WORD_W-1:0] rdata,
  output dma_cfg_t          cfg,
  output logic              start,
  input  dma_evt_t          evt,
  input  logic              busy
);

  logic wr_en;
  logic ctrl_wr;
  logic done_q;
  logic err_q;

  // full word writes only, no strobes
  assign wr_en   = req.valid && req.write;
  assign ctrl_wr = wr_en && (req.offset == REG_DMA_CTRL);

  // --------------------------------------------------------------------------
  // source and length registers
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg <= '0;
    end else if (wr_en) begin
      // writes while busy are not guarded
      case (req.offset)
        REG_SRC_ADDR:  cfg.src_addr  <= req.wdata;
        REG_LEN_WORDS: cfg.len_words <= req.wdata;
        default: begin
        end
      endcase
    end
  end

  // start is a one-cycle strobe, registered from the CTRL write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start <= 1'b0;
    end else begin
      start <= ctrl_wr && req.wdata[CTRL_START];
    end
  end

  // --------------------------------------------------------------------------
  // sticky status
  // --------------------------------------------------------------------------
  // write-one clears first, events afterwards so an event in the same
  // cycle overrides the clear
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_q <= 1'b0;
      err_q  <= 1'b0;
    end else begin
      if (ctrl_wr && req.wdata[CTRL_DONE]) begin
        done_q <= 1'b0;
      end
      if (ctrl_wr && req.wdata[CTRL_ERR]) begin
        err_q <= 1'b0;
      end
      // a legal start wipes the previous result
      if (evt.launch) begin
        done_q <= 1'b0;
        err_q  <= 1'b0;
      end
      if (evt.zero_len || evt.finish) begin
        done_q <= 1'b1;
      end
      // failed check flags both
      if (evt.reject) begin
        done_q <= 1'b1;
        err_q  <= 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // readback, combinational from the current offset
  // --------------------------------------------------------------------------
  always_comb begin
    rdata = '0;
    case (req.offset)
      REG_SRC_ADDR:  rdata = cfg.src_addr;
      REG_LEN_WORDS: rdata = cfg.len_words;
      REG_DMA_CTRL: begin
        // start bit always reads back as 0
        rdata[CTRL_DONE] = done_q;
        rdata[CTRL_ERR]  = err_q;
        rdata[CTRL_BUSY] = busy;
      end
      default: rdata = '0;
    endcase
  end

endmodule

//--- rtl/dma_xfer_seq.sv
// --------------------------------------------------------------------------
// DMA transfer sequencer, checks a start request and walks the window
// two words per FIFO entry, holding in PUSH while the FIFO is full
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module dma_xfer_seq
  import dma_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  dma_cfg_t    cfg,
  input  logic        start,
  input  logic        fifo_full,
  output dma_evt_t    evt,
  output logic        busy,
  output dma_rd_t     rd,
  output logic [31:0] rd_addr
);

  dma_state_e  state;
  dma_state_e  state_nxt;
  logic [31:0] addr_ptr;
  logic [31:0] words_rem;

  logic [31:0] end_addr;
  logic        len_odd;
  logic        len_zero;
  logic        misaligned;
  logic        outside;
  logic        push_ok;
  logic        last_pair;

  // --------------------------------------------------------------------------
  // request checks
  // --------------------------------------------------------------------------
  // last byte covered by the request, words times 4 minus one
  assign end_addr   = cfg.src_addr + {cfg.len_words[29:0], 2'b00} - 32'd1;
  assign len_odd    = cfg.len_words[0];
  assign len_zero   = (cfg.len_words == 32'd0);
  assign misaligned = (cfg.src_addr[1:0] != 2'b00);
  // below base, past end, a byte count beyond 32 bits, or the end address
  // wrapped around 2^32
  assign outside    = (cfg.src_addr < ADDR_DATA_BASE) || (end_addr > ADDR_DATA_END) ||
                      (cfg.len_words[31:30] != 2'b00) || (end_addr < cfg.src_addr);

  assign push_ok   = (state == ST_PUSH) && !fifo_full;
  assign last_pair = (words_rem == 32'd2);

  // events, one cycle each
  always_comb begin
    evt = '0;
    if ((state == ST_IDLE) && start) begin
      if (len_odd) begin
        evt.reject = 1'b1;
      end else if (len_zero) begin
        evt.zero_len = 1'b1;
      end else if (misaligned || outside) begin
        evt.reject = 1'b1;
      end else begin
        evt.launch = 1'b1;
      end
    end
    evt.finish = push_ok && last_pair;
  end

  // --------------------------------------------------------------------------
  // FSM
  // --------------------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:  if (evt.launch) state_nxt = ST_SETUP;
      // one spare cycle for the loaded pointer
      ST_SETUP: state_nxt = ST_RD0;
      ST_RD0:   state_nxt = ST_RD1;
      ST_RD1:   state_nxt = ST_PUSH;
      ST_PUSH: begin
        if (push_ok) begin
          state_nxt = last_pair ? ST_IDLE : ST_RD0;
        end
      end
      default:  state_nxt = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // pointer is a byte offset into the window, counter in words
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_ptr  <= '0;
      words_rem <= '0;
    end else begin
      if (evt.launch) begin
        addr_ptr  <= cfg.src_addr - ADDR_DATA_BASE;
        words_rem <= cfg.len_words;
      end
      if ((state == ST_RD0) || (state == ST_RD1)) begin
        addr_ptr <= addr_ptr + 32'd4;
      end
      // back-pressure leaves both untouched
      if (push_ok) begin
        words_rem <= words_rem - 32'd2;
      end
    end
  end

  // outputs decoded from the state
  assign busy    = (state != ST_IDLE);
  assign rd.en   = (state == ST_RD0) || (state == ST_RD1);
  assign rd.hi   = (state == ST_RD1);
  assign rd.push = push_ok;
  assign rd_addr = addr_ptr;

endmodule

//--- rtl/dma_pair_packer.sv
// --------------------------------------------------------------------------
// captures two read words and presents them as one 64-bit FIFO entry
// first word read lands in the low half
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module dma_pair_packer
  import dma_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  dma_rd_t            rd,
  input  logic [WORD_W-1:0]  rd_data,
  output logic               fifo_push,
  output logic [ENTRY_W-1:0] fifo_wdata
);

  logic [WORD_W-1:0] lo_q;
  logic [WORD_W-1:0] hi_q;

  // read data is valid in the read cycle, capture on the closing edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lo_q <= '0;
      hi_q <= '0;
    end else if (rd.en) begin
      if (rd.hi) begin
        hi_q <= rd_data;
      end else begin
        lo_q <= rd_data;
      end
    end
  end

  // entry stays staged here while the sequencer waits on full
  assign fifo_push = rd.push;

  // zero outside a push keeps the FIFO data bus quiet
  always_comb begin
    fifo_wdata = '0;
    if (rd.push) begin
      fifo_wdata = {hi_q, lo_q};
    end
  end

endmodule

//--- rtl/dma_engine.sv
// --------------------------------------------------------------------------
// DMA engine top, moves word pairs from the data memory into a 64-bit FIFO
// programmed through the SRC, LEN and CTRL registers
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module dma_engine
  import dma_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  // register bus
  input  dma_req_t           req,
  output logic [WORD_W-1:0]  rdata,
  // data memory read port, combinational
  output logic               rd_en,
  output logic [31:0]        rd_addr,
  input  logic [WORD_W-1:0]  rd_data,
  // downstream FIFO write port
  output logic               fifo_push,
  output logic [ENTRY_W-1:0] fifo_wdata,
  input  logic               fifo_full
);

  dma_cfg_t cfg;
  dma_evt_t evt;
  dma_rd_t  rd;
  logic     start;
  logic     busy;

  // registers, start strobe and sticky status
  dma_reg_decode u_reg (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .rdata (rdata),
    .cfg   (cfg),
    .start (start),
    .evt   (evt),
    .busy  (busy)
  );

  // checks and transfer sequencing
  dma_xfer_seq u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .start     (start),
    .fifo_full (fifo_full),
    .evt       (evt),
    .busy      (busy),
    .rd        (rd),
    .rd_addr   (rd_addr)
  );

  // pair staging towards the FIFO
  dma_pair_packer u_pack (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd         (rd),
    .rd_data    (rd_data),
    .fifo_push  (fifo_push),
    .fifo_wdata (fifo_wdata)
  );

  assign rd_en = rd.en;

endmodule

//--- dv/dma_engine_properties.sv
// --------------------------------------------------------------------------
// concurrent checks on the DMA engine FIFO, memory and status outputs
// bound into the DMA engine top by the testbench
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module dma_engine_properties (
  input logic clk,
  input logic rst_n,
  input logic rd_en,
  input logic fifo_push,
  input logic fifo_full,
  input logic done,
  input logic err
);

  // push is gated by full inside the sequencer
  push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
    fifo_push |-> !fifo_full)
    else $error("fifo_push asserted while fifo_full is high");

  // reads and pushes come from different states
  rd_push_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(rd_en && fifo_push))
    else $error("rd_en and fifo_push high in the same cycle");

  // err only rises together with done
  err_with_done: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(err) |-> done)
    else $error("err rose without done");

endmodule

//--- dv/dma_engine_tb.sv
// --------------------------------------------------------------------------
// DMA engine testbench, runs the cases of dv/dma_testdata.txt against
// memory and FIFO models and checks registers, flags and pushed entries
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module dma_engine_tb
  import dma_pkg::*;
();

  logic               clk;
  logic               rst_n;
  dma_req_t           req;
  logic [WORD_W-1:0]  rdata;
  logic               rd_en;
  logic [31:0]        rd_addr;
  logic [WORD_W-1:0]  rd_data;
  logic               fifo_push;
  logic [ENTRY_W-1:0] fifo_wdata;
  logic               fifo_full;

  logic [31:0]        mem [0:1023];
  logic [ENTRY_W-1:0] pushed [$];
  logic [31:0]        reads [$];
  int                 full_pct;
  int                 errors;
  int                 checks;
  logic               timed_out;

  dma_engine u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .rdata      (rdata),
    .rd_en      (rd_en),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .fifo_push  (fifo_push),
    .fifo_wdata (fifo_wdata),
    .fifo_full  (fifo_full)
  );

  bind dma_engine dma_engine_properties u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_en     (rd_en),
    .fifo_push (fifo_push),
    .fifo_full (fifo_full),
    .done      (u_reg.done_q),
    .err       (u_reg.err_q)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // memory and FIFO models
  // --------------------------------------------------------------------------
  // fill rule, word index times a constant plus an offset
  function automatic logic [31:0] fill_word(input logic [31:0] byte_off);
    return byte_off[31:2] * 32'h0100_0193 + 32'h5A5A_0000;
  endfunction

  assign rd_data = mem[rd_addr[11:2]];

  // back-pressure drawn per cycle against the case percentage
  always @(negedge clk) begin
    fifo_full = ($urandom % 100) < full_pct;
  end

  // pushed entries and memory read offsets, in order
  always @(posedge clk) begin
    if (rst_n && fifo_push) begin
      pushed.push_back(fifo_wdata);
    end
    if (rst_n && rd_en) begin
      reads.push_back(rd_addr);
    end
  end

  // --------------------------------------------------------------------------
  // bus access, checking and run control
  // --------------------------------------------------------------------------
  task automatic write_reg(input dma_reg_e off, input logic [31:0] data);
    @(negedge clk);
    req.valid  = 1'b1;
    req.write  = 1'b1;
    req.offset = off;
    req.wdata  = data;
    @(negedge clk);
    req.valid = 1'b0;
    req.write = 1'b0;
  endtask

  // rdata sampled at the rising edge, before any register update lands
  task automatic read_reg(input dma_reg_e off, output logic [31:0] data);
    @(negedge clk);
    req.valid  = 1'b1;
    req.write  = 1'b0;
    req.offset = off;
    req.wdata  = '0;
    @(posedge clk);
    data = rdata;
    @(negedge clk);
    req.valid = 1'b0;
  endtask

  task automatic compare_value(input logic [63:0] got, input logic [63:0] exp,
                               input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic end_run();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  // poll CTRL until done, two cycles per read
  task automatic wait_done(output logic [31:0] ctrl);
    int cycles;
    cycles = 0;
    ctrl   = '0;
    while (!ctrl[CTRL_DONE] && (cycles < 2000)) begin
      read_reg(REG_DMA_CTRL, ctrl);
      cycles += 2;
    end
    if (!ctrl[CTRL_DONE]) begin
      $display("DONE did not rise within %0d cycles", cycles);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic run_case(input logic [31:0] src, input logic [31:0] len,
                          input int exp_err, input int pct, input int clr);
    logic [31:0] val;
    logic [31:0] off;
    int          n_exp;
    string       tag;
    tag      = $sformatf("src %h len %0d", src, len);
    full_pct = pct;
    pushed.delete();
    reads.delete();
    write_reg(REG_SRC_ADDR, src);
    write_reg(REG_LEN_WORDS, len);
    read_reg(REG_SRC_ADDR, val);
    compare_value(val, src, {tag, " SRC readback"});
    read_reg(REG_LEN_WORDS, val);
    compare_value(val, len, {tag, " LEN readback"});
    write_reg(REG_DMA_CTRL, 32'h1 << CTRL_START);
    wait_done(val);
    if (timed_out) begin
      return;
    end
    compare_value(val[CTRL_ERR], exp_err[0], {tag, " err flag"});
    compare_value(val[CTRL_BUSY], 1'b0, {tag, " busy at done"});
    // rejected and zero-length requests push nothing
    n_exp = (exp_err != 0) ? 0 : int'(len / 2);
    compare_value(pushed.size(), n_exp, {tag, " push count"});
    off = src - ADDR_DATA_BASE;
    for (int k = 0; (k < pushed.size()) && (k < n_exp); k++) begin
      compare_value(pushed[k], {fill_word(off + 8 * k + 4), fill_word(off + 8 * k)},
                    $sformatf("%s entry %0d", tag, k));
    end
    // one read per word, walking up from the window offset
    compare_value(reads.size(), 2 * n_exp, {tag, " read count"});
    for (int j = 0; (j < reads.size()) && (j < 2 * n_exp); j++) begin
      compare_value(reads[j], off + 4 * j, $sformatf("%s read %0d", tag, j));
    end
    full_pct = 0;
    if (clr != 0) begin
      write_reg(REG_DMA_CTRL, (32'h1 << CTRL_DONE) | (32'h1 << CTRL_ERR));
      read_reg(REG_DMA_CTRL, val);
      compare_value(val, 32'h0, {tag, " CTRL after clear"});
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    int          fd;
    int          n;
    int          cases;
    string       line;
    logic [31:0] src;
    logic [31:0] len;
    int          exp_err;
    int          pct;
    int          clr;
    logic [31:0] val;
    void'($urandom(32'h9fa2_f339));
    errors    = 0;
    checks    = 0;
    cases     = 0;
    full_pct  = 0;
    timed_out = 1'b0;
    rst_n     = 1'b0;
    req       = '0;
    fifo_full = 1'b0;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = fill_word(32'(i) * 4);
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // reset values of all three registers
    read_reg(REG_SRC_ADDR, val);
    compare_value(val, 32'h0, "SRC after reset");
    read_reg(REG_LEN_WORDS, val);
    compare_value(val, 32'h0, "LEN after reset");
    read_reg(REG_DMA_CTRL, val);
    compare_value(val, 32'h0, "CTRL after reset");

    fd = $fopen("dv/dma_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file dv/dma_testdata.txt");
      errors++;
    end else begin
      while (!$feof(fd) && !timed_out) begin
        n = $fgets(line, fd);
        if ((n > 0) && (line.len() > 1) && (line.getc(0) != "#")) begin
          n = $sscanf(line, "%h %h %d %d %d", src, len, exp_err, pct, clr);
          if (n == 5) begin
            cases++;
            run_case(src, len, exp_err, pct, clr);
          end else begin
            $display("malformed test data line: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
    if (cases == 0) begin
      $display("no test cases were read from the test data file");
      errors++;
    end
    end_run();
  end

endmodule

//--- list.f
rtl/dma_pkg.sv
rtl/dma_reg_decode.sv
rtl/dma_xfer_seq.sv
rtl/dma_pair_packer.sv
rtl/dma_engine.sv
dv/dma_engine_properties.sv
dv/dma_engine_tb.sv

//--- dv/dma_testdata.txt
# src(hex) len_words(hex) exp_err full_pct(dec) clear
# clear 1 writes CTRL bits 1 and 2 after the case, 0 leaves done and err set
20000000 2 0 0 1
20000010 8 0 0 1
20000100 10 0 40 1
20000ff8 2 0 70 1
20000800 40 0 70 1
20000f00 40 0 60 1
20000000 200 0 30 1
20000000 3 1 0 1
20000002 4 1 0 1
1ffffff0 4 1 0 1
00000000 4 1 0 1
20000ffc 2 1 0 1
fffffff8 4 1 0 1
20000000 0 0 0 1
20000004 5 1 0 0
20000040 6 0 50 1
20000020 4 0 20 1
